//--- source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // base opcodes in inst[6:0]
  localparam logic [6:0] op_lui     = 7'b0110111;
  localparam logic [6:0] op_auipc   = 7'b0010111;
  localparam logic [6:0] op_jal     = 7'b1101111;
  localparam logic [6:0] op_jalr    = 7'b1100111;
  localparam logic [6:0] op_branch  = 7'b1100011;
  localparam logic [6:0] op_imm     = 7'b0010011;
  localparam logic [6:0] op_load    = 7'b0000011;
  localparam logic [6:0] op_store   = 7'b0100011;
  localparam logic [6:0] op_reg     = 7'b0110011;
  localparam logic [6:0] op_system  = 7'b1110011;
  localparam logic [6:0] op_fence_i = 7'b0001111;

  // alu op is {funct7[5], funct3}
  localparam logic [3:0] alu_add  = 4'b0000;
  localparam logic [3:0] alu_sub  = 4'b1000;
  localparam logic [3:0] alu_sll  = 4'b0001;
  localparam logic [3:0] alu_slt  = 4'b0010;
  localparam logic [3:0] alu_sltu = 4'b0011;
  localparam logic [3:0] alu_xor  = 4'b0100;
  localparam logic [3:0] alu_srl  = 4'b0101;
  localparam logic [3:0] alu_sra  = 4'b1101;
  localparam logic [3:0] alu_or   = 4'b0110;
  localparam logic [3:0] alu_and  = 4'b0111;

  // immediate format select
  localparam logic [2:0] fmt_i    = 3'd0;
  localparam logic [2:0] fmt_s    = 3'd1;
  localparam logic [2:0] fmt_b    = 3'd2;
  localparam logic [2:0] fmt_u    = 3'd3;
  localparam logic [2:0] fmt_j    = 3'd4;
  localparam logic [2:0] fmt_none = 3'd5;

endpackage

`default_nettype wire

//--- source/stage_pkg.sv
`default_nettype none

package stage_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // decode handshake fsm
  localparam logic st_idle       = 1'b0;
  localparam logic st_wait_ready = 1'b1;

endpackage

`default_nettype wire

//--- source/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen
  import rv_isa_pkg::*;
(
  input  wire  [31:0] inst_i,
  input  wire  [2:0]  fmt_i,
  output logic [31:0] imm_o
);

  logic [31:0] imm_i_ext;
  logic [31:0] imm_s_ext;
  logic [31:0] imm_b_ext;
  logic [31:0] imm_u_ext;
  logic [31:0] imm_j_ext;

  assign imm_i_ext = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s_ext = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  // b and j are halfword offsets
  assign imm_b_ext = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                      inst_i[11:8], 1'b0};
  assign imm_u_ext = {inst_i[31:12], 12'b0};
  assign imm_j_ext = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                      inst_i[30:21], 1'b0};

  always_comb begin
    case (fmt_i)
      rv_isa_pkg::fmt_i: imm_o = imm_i_ext;
      fmt_s:             imm_o = imm_s_ext;
      fmt_b:             imm_o = imm_b_ext;
      fmt_u:             imm_o = imm_u_ext;
      fmt_j:             imm_o = imm_j_ext;
      default:           imm_o = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import stage_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire  [reg_addr_w-1:0] rs1_i,
  input  wire  [reg_addr_w-1:0] rs2_i,
  output logic [xlen-1:0]       rdata1_o,
  output logic [xlen-1:0]       rdata2_o,
  input  wire                   wen_i,
  input  wire  [reg_addr_w-1:0] waddr_i,
  input  wire  [xlen-1:0]       wdata_i
);

  logic [xlen-1:0] regs [2**reg_addr_w];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 reads as zero whatever the array holds
  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

  // a written value reaches read port 1 one cycle later
  a_write_read: assert property (@(posedge clk) disable iff (rst)
    (wen_i && (waddr_i != '0)) |=>
      ((rs1_i != $past(waddr_i)) || (rdata1_o == $past(wdata_i))));

endmodule

`default_nettype wire

//--- source/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
  import rv_isa_pkg::*;
  import stage_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire  [31:0]           inst_i,
  input  wire  [xlen-1:0]       pc_i,
  input  wire                   prev_valid_i,
  input  wire                   next_ready_i,
  output logic                  valid_o,
  output logic                  ready_o,
  input  wire  [xlen-1:0]       rdata1_i,
  input  wire  [xlen-1:0]       rdata2_i,
  input  wire  [31:0]           imm_i,
  output logic [31:0]           inst_q_o,
  output logic [2:0]            fmt_o,
  output logic [reg_addr_w-1:0] rs1_o,
  output logic [reg_addr_w-1:0] rs2_o,
  output logic [reg_addr_w-1:0] rd_o,
  output logic                  rwen_o,
  output logic                  ren_o,
  output logic                  wen_o,
  output logic                  en_j_o,
  output logic                  illegal_o,
  output logic [3:0]            alu_op_o,
  output logic [xlen-1:0]       op1_o,
  output logic [xlen-1:0]       op2_o,
  output logic [xlen-1:0]       op_j_o,
  output logic [xlen-1:0]       rwaddr_o,
  output logic [xlen-1:0]       pc_o,
  output logic [31:0]           imm_o
);

  logic            state;
  logic [31:0]     inst_q;
  logic [xlen-1:0] pc_q;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            funct7_b5;
  logic            accept;

  assign accept = prev_valid_i && ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_idle;
      valid_o <= 1'b0;
      ready_o <= 1'b1;
    end else begin
      case (state)
        st_idle: begin
          if (prev_valid_i) begin
            state   <= st_wait_ready;
            valid_o <= 1'b1;
            ready_o <= 1'b0;
          end
        end
        default: begin
          if (next_ready_i) begin
            state   <= st_idle;
            valid_o <= 1'b0;
            ready_o <= 1'b1;
          end
        end
      endcase
    end
  end

  // held until the next stage takes it
  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  assign inst_q_o  = inst_q;
  assign pc_o      = pc_q;
  assign opcode    = inst_q[6:0];
  assign funct3    = inst_q[14:12];
  assign funct7_b5 = inst_q[30];
  assign rs1_o     = inst_q[19:15];
  assign rs2_o     = inst_q[24:20];
  // imm_gen gives zero for fmt_none
  assign imm_o     = imm_i;

  always_comb begin
    fmt_o     = fmt_none;
    rd_o      = '0;
    rwen_o    = 1'b0;
    ren_o     = 1'b0;
    wen_o     = 1'b0;
    en_j_o    = 1'b0;
    illegal_o = 1'b0;
    alu_op_o  = alu_add;
    op1_o     = '0;
    op2_o     = '0;
    op_j_o    = '0;
    rwaddr_o  = '0;
    case (opcode)
      op_lui, op_auipc: begin
        fmt_o  = fmt_u;
        rd_o   = inst_q[11:7];
        rwen_o = 1'b1;
        op1_o  = (opcode == op_auipc) ? pc_q : '0;
        op2_o  = imm_i;
      end
      op_jal, op_jalr: begin
        // link value is pc + 4
        fmt_o  = (opcode == op_jal) ? fmt_j : fmt_i;
        rd_o   = inst_q[11:7];
        rwen_o = 1'b1;
        en_j_o = 1'b1;
        op1_o  = pc_q;
        op2_o  = 32'd4;
        op_j_o = (opcode == op_jal) ? pc_q : rdata1_i;
      end
      op_branch: begin
        fmt_o    = fmt_b;
        en_j_o   = 1'b1;
        alu_op_o = {1'b0, funct3};
        op1_o    = rdata1_i;
        op2_o    = rdata2_i;
        op_j_o   = pc_q;
      end
      op_imm: begin
        fmt_o    = fmt_i;
        rd_o     = inst_q[11:7];
        rwen_o   = 1'b1;
        // only srli/srai carry funct7
        alu_op_o = {(funct3 == 3'b101) ? funct7_b5 : 1'b0, funct3};
        op1_o    = rdata1_i;
        op2_o    = imm_i;
      end
      op_load: begin
        fmt_o    = fmt_i;
        rd_o     = inst_q[11:7];
        rwen_o   = 1'b1;
        ren_o    = 1'b1;
        alu_op_o = {1'b0, funct3};
        op1_o    = rdata1_i;
        op2_o    = imm_i;
        op_j_o   = rdata1_i;
        rwaddr_o = rdata1_i + imm_i;
      end
      op_store: begin
        fmt_o    = fmt_s;
        wen_o    = 1'b1;
        alu_op_o = {1'b0, funct3};
        op1_o    = rdata1_i;
        op2_o    = rdata2_i;
        op_j_o   = rdata1_i;
        rwaddr_o = rdata1_i + imm_i;
      end
      op_reg: begin
        rd_o     = inst_q[11:7];
        rwen_o   = 1'b1;
        alu_op_o = {funct7_b5, funct3};
        op1_o    = rdata1_i;
        op2_o    = rdata2_i;
      end
      op_system: begin
        fmt_o    = fmt_i;
        en_j_o   = 1'b1;
        alu_op_o = {1'b0, funct3};
        op1_o    = rdata1_i;
      end
      op_fence_i: begin
        // no operation here
        fmt_o = fmt_none;
      end
      default: begin
        illegal_o = valid_o;
      end
    endcase
  end

  a_vr_excl: assert property (@(posedge clk) disable iff (rst)
    !(valid_o && ready_o));

  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    (valid_o && !next_ready_i) |=> $stable(inst_q_o));

endmodule

`default_nettype wire

//--- source/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top
  import stage_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   prev_valid_i,
  input  wire  [31:0]           inst_i,
  input  wire  [xlen-1:0]       pc_i,
  output logic                  ready_o,
  output logic                  valid_o,
  input  wire                   next_ready_i,
  input  wire                   wb_en_i,
  input  wire  [reg_addr_w-1:0] wb_addr_i,
  input  wire  [xlen-1:0]       wb_data_i,
  output logic [reg_addr_w-1:0] rs1_o,
  output logic [reg_addr_w-1:0] rs2_o,
  output logic [reg_addr_w-1:0] rd_o,
  output logic                  rwen_o,
  output logic                  ren_o,
  output logic                  wen_o,
  output logic                  en_j_o,
  output logic                  illegal_o,
  output logic [3:0]            alu_op_o,
  output logic [xlen-1:0]       op1_o,
  output logic [xlen-1:0]       op2_o,
  output logic [xlen-1:0]       op_j_o,
  output logic [xlen-1:0]       rwaddr_o,
  output logic [xlen-1:0]       pc_o,
  output logic [31:0]           imm_o
);

  logic [xlen-1:0] rdata1;
  logic [xlen-1:0] rdata2;
  logic [31:0]     imm;
  logic [31:0]     inst_q;
  logic [2:0]      fmt;

  inst_decoder u_dec (
    .clk          (clk),
    .rst          (rst),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .prev_valid_i (prev_valid_i),
    .next_ready_i (next_ready_i),
    .valid_o      (valid_o),
    .ready_o      (ready_o),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .imm_i        (imm),
    .inst_q_o     (inst_q),
    .fmt_o        (fmt),
    .rs1_o        (rs1_o),
    .rs2_o        (rs2_o),
    .rd_o         (rd_o),
    .rwen_o       (rwen_o),
    .ren_o        (ren_o),
    .wen_o        (wen_o),
    .en_j_o       (en_j_o),
    .illegal_o    (illegal_o),
    .alu_op_o     (alu_op_o),
    .op1_o        (op1_o),
    .op2_o        (op2_o),
    .op_j_o       (op_j_o),
    .rwaddr_o     (rwaddr_o),
    .pc_o         (pc_o),
    .imm_o        (imm_o)
  );

  imm_gen u_imm (
    .inst_i (inst_q),
    .fmt_i  (fmt),
    .imm_o  (imm)
  );

  // read ports follow the held instruction
  reg_file u_rf (
    .clk      (clk),
    .rst      (rst),
    .rs1_i    (rs1_o),
    .rs2_i    (rs2_o),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .wen_i    (wb_en_i),
    .waddr_i  (wb_addr_i),
    .wdata_i  (wb_data_i)
  );

endmodule

`default_nettype wire

//--- dv/tb_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode
  import rv_isa_pkg::*;
  import stage_pkg::*;
();

  localparam int clk_period = 100;
  localparam int n_rows     = 16;

  // expected flag bits: rwen ren wen en_j illegal
  localparam logic [4:0] f_rwen = 5'b10000;
  localparam logic [4:0] f_ren  = 5'b01000;
  localparam logic [4:0] f_wen  = 5'b00100;
  localparam logic [4:0] f_j    = 5'b00010;
  localparam logic [4:0] f_ill  = 5'b00001;

  typedef struct {
    logic [31:0] inst;
    logic [31:0] pc;
    logic [3:0]  alu_op;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] imm;
    logic [4:0]  rd;
    logic [4:0]  flags;
    logic [31:0] op_j;
    logic [31:0] rwaddr;
  } row_t;

  logic                  clk;
  logic                  rst;
  logic                  prev_valid_i;
  logic [31:0]           inst_i;
  logic [xlen-1:0]       pc_i;
  logic                  ready_o;
  logic                  valid_o;
  logic                  next_ready_i;
  logic                  wb_en_i;
  logic [reg_addr_w-1:0] wb_addr_i;
  logic [xlen-1:0]       wb_data_i;
  logic [reg_addr_w-1:0] rs1_o;
  logic [reg_addr_w-1:0] rs2_o;
  logic [reg_addr_w-1:0] rd_o;
  logic                  rwen_o;
  logic                  ren_o;
  logic                  wen_o;
  logic                  en_j_o;
  logic                  illegal_o;
  logic [3:0]            alu_op_o;
  logic [xlen-1:0]       op1_o;
  logic [xlen-1:0]       op2_o;
  logic [xlen-1:0]       op_j_o;
  logic [xlen-1:0]       rwaddr_o;
  logic [xlen-1:0]       pc_o;
  logic [31:0]           imm_o;

  row_t        rows [n_rows];
  logic [31:0] model [32];
  int          n_filled;
  int          errors;
  int          seed;

  decode_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // instruction encoders take immediates as 32-bit values
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [31:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] u_type(input logic [31:0] imm, input logic [4:0] rd,
      input logic [6:0] op);
    return {imm[31:12], rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  task automatic add_row(input logic [31:0] inst, input logic [31:0] pc, input logic [3:0] alu,
      input logic [31:0] op1, input logic [31:0] op2, input logic [31:0] imm,
      input logic [4:0] rd, input logic [4:0] flags, input logic [31:0] op_j,
      input logic [31:0] rwaddr);
    rows[n_filled] = '{inst, pc, alu, op1, op2, imm, rd, flags, op_j, rwaddr};
    n_filled++;
  endtask

  task automatic build_table();
    // x0 operands read as zero
    add_row(r_type(7'h00, 5'd7, 5'd0, 3'b000, 5'd5), 32'h0, alu_add,
            32'h0, model[7], 32'h0, 5'd5, f_rwen, 32'h0, 32'h0);
    add_row(r_type(7'h20, 5'd0, 5'd3, 3'b000, 5'd8), 32'h0, alu_sub,
            model[3], 32'h0, 32'h0, 5'd8, f_rwen, 32'h0, 32'h0);
    add_row(r_type(7'h20, 5'd11, 5'd10, 3'b101, 5'd9), 32'h0, alu_sra,
            model[10], model[11], 32'h0, 5'd9, f_rwen, 32'h0, 32'h0);
    add_row(i_type(32'hfffffff8, 5'd13, 3'b000, 5'd12, op_imm), 32'h0, alu_add,
            model[13], 32'hfffffff8, 32'hfffffff8, 5'd12, f_rwen, 32'h0, 32'h0);
    // srai carries the funct7 bit in the immediate
    add_row(i_type(32'h00000403, 5'd15, 3'b101, 5'd14, op_imm), 32'h0, alu_sra,
            model[15], 32'h403, 32'h403, 5'd14, f_rwen, 32'h0, 32'h0);
    add_row(u_type(32'hdeadb000, 5'd16, op_lui), 32'h0, alu_add,
            32'h0, 32'hdeadb000, 32'hdeadb000, 5'd16, f_rwen, 32'h0, 32'h0);
    add_row(u_type(32'h12345000, 5'd17, op_auipc), 32'h100, alu_add,
            32'h100, 32'h12345000, 32'h12345000, 5'd17, f_rwen, 32'h0, 32'h0);
    add_row(i_type(32'd20, 5'd19, 3'b010, 5'd18, op_load), 32'h0, 4'b0010,
            model[19], 32'd20, 32'd20, 5'd18, f_rwen | f_ren,
            model[19], model[19] + 32'd20);
    add_row(i_type(32'hfffffff8, 5'd21, 3'b000, 5'd20, op_load), 32'h0, 4'b0000,
            model[21], 32'hfffffff8, 32'hfffffff8, 5'd20, f_rwen | f_ren,
            model[21], model[21] - 32'd8);
    add_row(s_type(32'hfffff804, 5'd22, 5'd23, 3'b010), 32'h0, 4'b0010,
            model[23], model[22], 32'hfffff804, 5'd0, f_wen,
            model[23], model[23] - 32'd2044);
    add_row(j_type(32'hfff54aaa, 5'd1), 32'h2000, alu_add,
            32'h2000, 32'd4, 32'hfff54aaa, 5'd1, f_rwen | f_j, 32'h2000, 32'h0);
    add_row(i_type(32'd12, 5'd24, 3'b000, 5'd2, op_jalr), 32'h3000, alu_add,
            32'h3000, 32'd4, 32'd12, 5'd2, f_rwen | f_j, model[24], 32'h0);
    add_row(b_type(32'hfffff556, 5'd26, 5'd25, 3'b001), 32'h4000, 4'b0001,
            model[25], model[26], 32'hfffff556, 5'd0, f_j, 32'h4000, 32'h0);
    add_row(i_type(32'h305, 5'd27, 3'b010, 5'd0, op_system), 32'h5000, 4'b0010,
            model[27], 32'h0, 32'h305, 5'd0, f_j, 32'h0, 32'h0);
    add_row(i_type(32'h0, 5'd0, 3'b001, 5'd0, op_fence_i), 32'h6000, alu_add,
            32'h0, 32'h0, 32'h0, 5'd0, 5'b00000, 32'h0, 32'h0);
    // opcode 7'h7f is not rv32i
    add_row(32'h1234507f, 32'h7000, alu_add,
            32'h0, 32'h0, 32'h0, 5'd0, f_ill, 32'h0, 32'h0);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_outputs(input row_t r);
    check_val("alu_op_o", 32'(r.alu_op), 32'(alu_op_o));
    check_val("op1_o", r.op1, op1_o);
    check_val("op2_o", r.op2, op2_o);
    check_val("imm_o", r.imm, imm_o);
    check_val("rd_o", 32'(r.rd), 32'(rd_o));
    check_val("rs1_o", 32'(r.inst[19:15]), 32'(rs1_o));
    check_val("rs2_o", 32'(r.inst[24:20]), 32'(rs2_o));
    check_val("rwen_o", 32'(r.flags[4]), 32'(rwen_o));
    check_val("ren_o", 32'(r.flags[3]), 32'(ren_o));
    check_val("wen_o", 32'(r.flags[2]), 32'(wen_o));
    check_val("en_j_o", 32'(r.flags[1]), 32'(en_j_o));
    check_val("illegal_o", 32'(r.flags[0]), 32'(illegal_o));
    check_val("op_j_o", r.op_j, op_j_o);
    check_val("rwaddr_o", r.rwaddr, rwaddr_o);
    check_val("pc_o", r.pc, pc_o);
  endtask

  // called on a falling edge, returns once valid_o is up
  task automatic offer(input logic [31:0] inst, input logic [31:0] pc);
    int waited;
    waited = 0;
    inst_i = inst;
    pc_i = pc;
    prev_valid_i = 1'b1;
    @(negedge clk);
    while (!valid_o && waited < 10) begin
      @(negedge clk);
      waited++;
    end
    if (!valid_o) begin
      $display("instruction %h was not accepted within 10 cycles", inst);
      errors++;
    end
    prev_valid_i = 1'b0;
  endtask

  task automatic hand_on();
    next_ready_i = 1'b1;
    @(negedge clk);
    next_ready_i = 1'b0;
    prev_valid_i = 1'b0;
    check_val("valid_o", 32'd0, 32'(valid_o));
    check_val("ready_o", 32'd1, 32'(ready_o));
  endtask

  task automatic write_reg(input int addr, input logic [31:0] data);
    wb_en_i = 1'b1;
    wb_addr_i = addr[4:0];
    wb_data_i = data;
    @(negedge clk);
    wb_en_i = 1'b0;
  endtask

  initial begin
    int hold;
    seed = 32'h27fd;
    errors = 0;
    n_filled = 0;
    rst = 1'b1;
    prev_valid_i = 1'b0;
    inst_i = '0;
    pc_i = '0;
    next_ready_i = 1'b0;
    wb_en_i = 1'b0;
    wb_addr_i = '0;
    wb_data_i = '0;
    model[0] = '0;
    for (int i = 1; i < 32; i++) begin
      model[i] = $random(seed);
    end
    build_table();

    repeat (8) @(negedge clk);
    rst = 1'b0;
    check_val("valid_o", 32'd0, 32'(valid_o));
    check_val("ready_o", 32'd1, 32'(ready_o));

    // x0 write must be dropped
    write_reg(0, 32'hffffffff);
    for (int i = 1; i < 32; i++) begin
      write_reg(i, model[i]);
    end

    for (int r = 0; r < n_rows; r++) begin
      offer(rows[r].inst, rows[r].pc);
      check_outputs(rows[r]);
      hand_on();
    end

    // writeback lands while the add is held
    offer(r_type(7'h00, 5'd7, 5'd6, 3'b000, 5'd5), 32'h500);
    check_val("op1_o", model[6], op1_o);
    model[6] = $random(seed);
    write_reg(6, model[6]);
    check_val("op1_o", model[6], op1_o);
    hand_on();

    // back-pressure with a different instruction waiting
    hold = 1 + ($unsigned($random(seed)) % 5);
    offer(rows[2].inst, rows[2].pc);
    inst_i = rows[5].inst;
    pc_i = rows[5].pc;
    prev_valid_i = 1'b1;
    repeat (hold) begin
      @(negedge clk);
      check_outputs(rows[2]);
      check_val("ready_o", 32'd0, 32'(ready_o));
      check_val("valid_o", 32'd1, 32'(valid_o));
    end
    hand_on();

    repeat (2) @(negedge clk);
    $display("decode checks done with %0d error(s)", errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #((n_rows * 20 + 100) * clk_period);
    $display("timeout, run did not end within %0d cycles", n_rows * 20 + 100);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
source/rv_isa_pkg.sv
source/stage_pkg.sv
source/imm_gen.sv
source/reg_file.sv
source/inst_decoder.sv
source/decode_top.sv
dv/tb_decode.sv

//--- Makefile
TOP := tb_decode

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
